// File: rtl/rp_pkg.sv
// analog front end shared definitions
// sample widths, bus region map, housekeeping register offsets
// bus request/response and housekeeping config structs
package rp_pkg;

  // ------------------------------------------------------------
  // datapath widths
  // ------------------------------------------------------------
  localparam int SAMPLE_W = 14;  // converted ADC/DAC sample
  localparam int RAW_W    = 16;  // ADC pin bus, two low bits reserved
  localparam int RB_W     = 16;  // radio output sample

  // ------------------------------------------------------------
  // system bus address map
  // ------------------------------------------------------------
  localparam int REGION_LSB = 20;  // region field starts here
  localparam int N_REGIONS  = 8;

  // region 0 housekeeping offsets
  localparam logic [REGION_LSB-1:0] HK_ID_OFS   = 20'h0_0000;  // read only
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS = 20'h0_0004;  // digital loopback
  localparam logic [REGION_LSB-1:0] HK_LED_OFS  = 20'h0_0008;  // led value
  localparam logic [REGION_LSB-1:0] HK_RB_OFS   = 20'h0_000C;  // radio override

  localparam logic [31:0] HK_ID_VALUE = 32'h5250_0001;

  // bus master side, strobes are one cycle wide
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;
    logic        ren;
  } sys_req_t;

  // slave side, ack one cycle after the strobe
  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
    logic        err;
  } sys_rsp_t;

  // housekeeping config toward the datapath
  typedef struct packed {
    logic       digital_loop;
    logic       rb_active;
    logic [7:0] hk_led;
  } hk_cfg_t;

endpackage

// File: rtl/rp_bus_ctrl.sv
// system bus control
// region decode, housekeeping registers, registered response
// unused slave answer for regions 1..7, led source select
`timescale 1ns/1ps

module rp_bus_ctrl (
  input  logic             adc_clk,
  input  logic             reset_i,
  input  rp_pkg::sys_req_t req_i,     // from bus master
  input  logic [7:0]       rb_led_i,  // radio led pattern
  output rp_pkg::sys_rsp_t rsp_o,
  output rp_pkg::hk_cfg_t  cfg_o,
  output logic [7:0]       led_o
);
  import rp_pkg::*;

  localparam int RGN_W = $clog2(N_REGIONS);  // region field width

  // ------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------
  logic [RGN_W-1:0]      region;
  logic [REGION_LSB-1:0] offset;
  logic                  strobe;     // read or write this cycle
  logic                  hk_sel;     // region 0 addressed
  logic                  ofs_valid;  // offset is a known register
  logic [31:0]           hk_rdata;

  // response registers
  logic        ack_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // housekeeping registers
  logic       digital_loop_q;
  logic       rb_active_q;
  logic [7:0] hk_led_q;

  assign region = req_i.addr[REGION_LSB +: RGN_W];
  assign offset = req_i.addr[REGION_LSB-1:0];  // offset within region
  assign strobe = req_i.wen | req_i.ren;
  assign hk_sel = (region == '0);

  // read mux and offset check
  always_comb begin
    ofs_valid = 1'b1;
    hk_rdata  = '0;
    case (offset)
      HK_ID_OFS:   hk_rdata         = HK_ID_VALUE;
      HK_LOOP_OFS: hk_rdata[0]      = digital_loop_q;
      HK_LED_OFS:  hk_rdata[7:0]    = hk_led_q;
      HK_RB_OFS:   hk_rdata[0]      = rb_active_q;
      default:     ofs_valid        = 1'b0;  // hole in region 0
    endcase
  end

  // ------------------------------------------------------------
  // housekeeping register writes
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      digital_loop_q <= 1'b0;
      rb_active_q    <= 1'b0;
      hk_led_q       <= '0;
    end else if (req_i.wen && hk_sel) begin
      case (offset)
        HK_LOOP_OFS: digital_loop_q <= req_i.wdata[0];
        HK_LED_OFS:  hk_led_q       <= req_i.wdata[7:0];
        HK_RB_OFS:   rb_active_q    <= req_i.wdata[0];
        default:     ;  // id write dropped, holes flagged by err
      endcase
    end
  end

  // ------------------------------------------------------------
  // response, one cycle after the strobe
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= strobe;  // every region answers
      err_q <= strobe & hk_sel & ~ofs_valid;
    end
  end

  // zero on writes and on regions 1..7
  always_ff @(posedge adc_clk) begin
    rdata_q <= (req_i.ren && hk_sel) ? hk_rdata : '0;
  end

  assign rsp_o = '{rdata: rdata_q, ack: ack_q, err: err_q};

  assign cfg_o = '{
    digital_loop: digital_loop_q,
    rb_active:    rb_active_q,
    hk_led:       hk_led_q
  };

  // radio takes the leds while it drives the DAC
  assign led_o = rb_active_q ? rb_led_i : hk_led_q;

endmodule

// File: rtl/rp_adc_frontend.sv
// ADC capture
// input register on both channels, negative slope code to two's complement
// digital loopback select
`timescale 1ns/1ps

module rp_adc_frontend #(
  parameter int DATA_W = rp_pkg::SAMPLE_W
) (
  input  logic                     adc_clk,
  input  logic                     reset_i,
  input  logic [rp_pkg::RAW_W-1:0] adc_dat_a_i,  // raw ADC ch a
  input  logic [rp_pkg::RAW_W-1:0] adc_dat_b_i,  // raw ADC ch b
  input  logic                     loop_en_i,
  input  logic signed [DATA_W-1:0] loop_a_i,     // saturated DAC sum
  input  logic signed [DATA_W-1:0] loop_b_i,
  output logic signed [DATA_W-1:0] adc_a_o,
  output logic signed [DATA_W-1:0] adc_b_o
);
  import rp_pkg::*;

  logic [DATA_W-1:0] adc_a_q;  // offset code, reserved bits gone
  logic [DATA_W-1:0] adc_b_q;

  // msb kept, rest inverted
  function automatic logic signed [DATA_W-1:0] neg_slope_conv(
    input logic [DATA_W-1:0] code
  );
    return {code[DATA_W-1], ~code[DATA_W-2:0]};
  endfunction

  // ------------------------------------------------------------
  // input register
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      adc_a_q <= '0;
      adc_b_q <= '0;
    end else begin
      // upper bits only, low two are reserved
      adc_a_q <= adc_dat_a_i[RAW_W-1 -: DATA_W];
      adc_b_q <= adc_dat_b_i[RAW_W-1 -: DATA_W];
    end
  end

  // loopback bypasses the register, same cycle as the sum
  assign adc_a_o = loop_en_i ? loop_a_i : neg_slope_conv(adc_a_q);
  assign adc_b_o = loop_en_i ? loop_b_i : neg_slope_conv(adc_b_q);

endmodule

// File: rtl/rp_dac_backend.sv
// DAC output path
// generator + controller summation with 14 bit saturation
// radio override and negative slope DAC code register
`timescale 1ns/1ps

module rp_dac_backend #(
  parameter int DATA_W = rp_pkg::SAMPLE_W
) (
  input  logic                           adc_clk,
  input  logic                           reset_i,
  input  logic signed [DATA_W-1:0]       gen_a_i,   // generator ch a
  input  logic signed [DATA_W-1:0]       gen_b_i,
  input  logic signed [DATA_W-1:0]       ctl_a_i,   // controller ch a
  input  logic signed [DATA_W-1:0]       ctl_b_i,
  input  logic                           rb_active_i,
  input  logic signed [rp_pkg::RB_W-1:0] rb_a_i,    // radio sample ch a
  input  logic signed [rp_pkg::RB_W-1:0] rb_b_i,
  output logic signed [DATA_W-1:0]       sum_a_o,   // saturated, to loopback
  output logic signed [DATA_W-1:0]       sum_b_o,
  output logic [DATA_W-1:0]              dac_a_o,   // DAC code
  output logic [DATA_W-1:0]              dac_b_o
);
  import rp_pkg::*;

  localparam int SUM_W = DATA_W + 1;  // one guard bit for the add

  // code for a zero sample, msb clear and the rest set
  localparam logic [DATA_W-1:0] DAC_ZERO = {1'b0, {(DATA_W-1){1'b1}}};

  logic signed [SUM_W-1:0] sum_a;
  logic signed [SUM_W-1:0] sum_b;
  logic [DATA_W-1:0]       dac_a_q;
  logic [DATA_W-1:0]       dac_b_q;

  // clip to full scale when the top two bits disagree
  function automatic logic signed [DATA_W-1:0] sat_sum(
    input logic signed [SUM_W-1:0] s
  );
    if (s[SUM_W-1] != s[SUM_W-2]) begin
      return {s[SUM_W-1], {(DATA_W-1){~s[SUM_W-1]}}};
    end
    return s[DATA_W-1:0];
  endfunction

  // two's complement to negative slope offset code
  function automatic logic [DATA_W-1:0] dac_code(input logic signed [DATA_W-1:0] v);
    return {v[DATA_W-1], ~v[DATA_W-2:0]};
  endfunction

  // radio sample, upper bits only
  function automatic logic [DATA_W-1:0] rb_code(input logic signed [RB_W-1:0] r);
    return {r[RB_W-1], ~r[RB_W-2 -: DATA_W-1]};
  endfunction

  // ------------------------------------------------------------
  // summation and saturation
  // ------------------------------------------------------------
  assign sum_a   = gen_a_i + ctl_a_i;  // sign extended to SUM_W
  assign sum_b   = gen_b_i + ctl_b_i;
  assign sum_a_o = sat_sum(sum_a);
  assign sum_b_o = sat_sum(sum_b);

  // ------------------------------------------------------------
  // output register
  // ------------------------------------------------------------
  always_ff @(posedge adc_clk) begin
    if (reset_i) begin
      dac_a_q <= DAC_ZERO;
      dac_b_q <= DAC_ZERO;
    end else if (rb_active_i) begin
      dac_a_q <= rb_code(rb_a_i);  // radio owns the DAC
      dac_b_q <= rb_code(rb_b_i);
    end else begin
      dac_a_q <= dac_code(sum_a_o);
      dac_b_q <= dac_code(sum_b_o);
    end
  end

  assign dac_a_o = dac_a_q;
  assign dac_b_o = dac_b_q;

endmodule

// File: rtl/rp_analog_top.sv
// analog front end top level
// bus control, ADC capture and DAC output path on adc_clk
`timescale 1ns/1ps

module rp_analog_top #(
  parameter int DATA_W = rp_pkg::SAMPLE_W
) (
  input  logic                           adc_clk,
  input  logic                           reset_i,
  // ADC pins
  input  logic [rp_pkg::RAW_W-1:0]       adc_dat_a_i,
  input  logic [rp_pkg::RAW_W-1:0]       adc_dat_b_i,
  // generator and controller samples
  input  logic signed [DATA_W-1:0]       gen_a_i,
  input  logic signed [DATA_W-1:0]       gen_b_i,
  input  logic signed [DATA_W-1:0]       ctl_a_i,
  input  logic signed [DATA_W-1:0]       ctl_b_i,
  // radio
  input  logic signed [rp_pkg::RB_W-1:0] rb_a_i,
  input  logic signed [rp_pkg::RB_W-1:0] rb_b_i,
  input  logic [7:0]                     rb_led_i,
  // system bus
  input  rp_pkg::sys_req_t               req_i,
  output rp_pkg::sys_rsp_t               rsp_o,
  // converted samples and DAC codes
  output logic signed [DATA_W-1:0]       adc_a_o,
  output logic signed [DATA_W-1:0]       adc_b_o,
  output logic [DATA_W-1:0]              dac_a_o,
  output logic [DATA_W-1:0]              dac_b_o,
  output logic [7:0]                     led_o
);
  import rp_pkg::*;

  hk_cfg_t                  cfg;    // housekeeping config
  logic signed [DATA_W-1:0] sum_a;  // saturated sums, loopback source
  logic signed [DATA_W-1:0] sum_b;

  // ------------------------------------------------------------
  // bus decode, registers, leds
  // ------------------------------------------------------------
  rp_bus_ctrl u_bus_ctrl (
    .adc_clk  (adc_clk),
    .reset_i  (reset_i),
    .req_i    (req_i),
    .rb_led_i (rb_led_i),
    .rsp_o    (rsp_o),
    .cfg_o    (cfg),
    .led_o    (led_o)
  );

  // ------------------------------------------------------------
  // datapath
  // ------------------------------------------------------------
  rp_adc_frontend #(.DATA_W(DATA_W)) u_adc_frontend (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a_i),
    .adc_dat_b_i (adc_dat_b_i),
    .loop_en_i   (cfg.digital_loop),
    .loop_a_i    (sum_a),
    .loop_b_i    (sum_b),
    .adc_a_o     (adc_a_o),
    .adc_b_o     (adc_b_o)
  );

  rp_dac_backend #(.DATA_W(DATA_W)) u_dac_backend (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .gen_a_i     (gen_a_i),
    .gen_b_i     (gen_b_i),
    .ctl_a_i     (ctl_a_i),
    .ctl_b_i     (ctl_b_i),
    .rb_active_i (cfg.rb_active),
    .rb_a_i      (rb_a_i),
    .rb_b_i      (rb_b_i),
    .sum_a_o     (sum_a),
    .sum_b_o     (sum_b),
    .dac_a_o     (dac_a_o),
    .dac_b_o     (dac_b_o)
  );

endmodule

// File: bench/rp_analog_assertions.sv
// bus protocol assertions for the control module
// ack timing, err only with ack, quiet response during reset
`timescale 1ns/1ps

module rp_analog_assertions (
  input logic             adc_clk,
  input logic             reset_i,
  input rp_pkg::sys_req_t req_i,
  input rp_pkg::sys_rsp_t rsp_i
);

  logic        strobe;
  int unsigned fail_cnt = 0;  // failed assertions so far

  assign strobe = req_i.wen | req_i.ren;

  // ack exactly one cycle after a strobe
  ack_after_strobe: assert property (@(posedge adc_clk) disable iff (reset_i)
    strobe |=> rsp_i.ack)
    else begin
      fail_cnt++;
      $error("ack missing one cycle after a strobe");
    end

  // and never without one
  no_spurious_ack: assert property (@(posedge adc_clk) disable iff (reset_i)
    !strobe |=> !rsp_i.ack)
    else begin
      fail_cnt++;
      $error("ack without a preceding strobe");
    end

  err_needs_ack: assert property (@(posedge adc_clk) rsp_i.err |-> rsp_i.ack)
    else begin
      fail_cnt++;
      $error("err raised without ack");
    end

  // response register cleared once reset has been seen
  ack_low_in_reset: assert property (@(posedge adc_clk)
    (reset_i && $past(reset_i)) |-> !rsp_i.ack)
    else begin
      fail_cnt++;
      $error("ack high during reset");
    end

endmodule

bind rp_bus_ctrl rp_analog_assertions u_assertions (
  .adc_clk (adc_clk),
  .reset_i (reset_i),
  .req_i   (req_i),
  .rsp_i   (rsp_o)
);

// File: bench/tb_rp_analog.sv
// testbench for the analog front end top level
// clock, reset, random and corner stimulus, bus register tests
// reference model, compare process, timeout guard
`timescale 1ns/1ps

module tb_rp_analog;
  import rp_pkg::*;

  localparam int DW           = SAMPLE_W;
  localparam int HALF_PERIOD  = 5;               // 10 ns clock
  localparam int RESET_CYCLES = 5;
  localparam int MAXV         = (1 << (DW-1)) - 1;
  localparam int MINV         = -(1 << (DW-1));
  localparam int ACK_WAIT     = 4;               // cycles to wait for ack

  // stimulus length, bus ops take up to 3 cycles each
  localparam int N_ADC          = 2000;
  localparam int N_DAC          = 1000;
  localparam int N_LOOP         = 200;
  localparam int N_RB           = 200;
  localparam int N_BUS          = 40;
  localparam int STIM_CYCLES    = RESET_CYCLES + N_ADC + N_DAC + N_LOOP + N_RB + 3*N_BUS + 20;
  localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

  logic                   adc_clk;
  logic                   reset_i;
  logic [RAW_W-1:0]       adc_dat_a;
  logic [RAW_W-1:0]       adc_dat_b;
  logic signed [DW-1:0]   gen_a;
  logic signed [DW-1:0]   gen_b;
  logic signed [DW-1:0]   ctl_a;
  logic signed [DW-1:0]   ctl_b;
  logic signed [RB_W-1:0] rb_a;
  logic signed [RB_W-1:0] rb_b;
  logic [7:0]             rb_led;
  sys_req_t               req;
  sys_rsp_t               rsp;
  logic signed [DW-1:0]   adc_a;
  logic signed [DW-1:0]   adc_b;
  logic [DW-1:0]          dac_a;
  logic [DW-1:0]          dac_b;
  logic [7:0]             led;

  // reference model state
  hk_cfg_t              mdl_cfg;     // expected housekeeping regs
  logic [DW-1:0]        adc_code_a;  // expected ADC register content
  logic [DW-1:0]        adc_code_b;
  logic [DW-1:0]        exp_dac_a;
  logic [DW-1:0]        exp_dac_b;
  logic signed [DW-1:0] exp_adc_a;
  logic signed [DW-1:0] exp_adc_b;
  logic [7:0]           exp_led;
  logic                 pred_valid;  // model has seen a clock edge
  int                   cycle_cnt;

  rp_analog_top #(.DATA_W(DW)) u_rp_analog_top (
    .adc_clk     (adc_clk),
    .reset_i     (reset_i),
    .adc_dat_a_i (adc_dat_a),
    .adc_dat_b_i (adc_dat_b),
    .gen_a_i     (gen_a),
    .gen_b_i     (gen_b),
    .ctl_a_i     (ctl_a),
    .ctl_b_i     (ctl_b),
    .rb_a_i      (rb_a),
    .rb_b_i      (rb_b),
    .rb_led_i    (rb_led),
    .req_i       (req),
    .rsp_o       (rsp),
    .adc_a_o     (adc_a),
    .adc_b_o     (adc_b),
    .dac_a_o     (dac_a),
    .dac_b_o     (dac_b),
    .led_o       (led)
  );

  always #HALF_PERIOD adc_clk = ~adc_clk;

  // ------------------------------------------------------------
  // reference functions
  // ------------------------------------------------------------
  // negative slope offset code, full scale minus code
  function automatic logic signed [DW-1:0] ref_adc_conv(input logic [DW-1:0] code);
    int v;
    v = MAXV - int'(code);
    return v[DW-1:0];
  endfunction

  function automatic logic signed [DW-1:0] ref_sat_sum(
    input logic signed [DW-1:0] a,
    input logic signed [DW-1:0] b
  );
    int s;
    s = int'(a) + int'(b);
    if (s > MAXV) s = MAXV;       // clip high
    else if (s < MINV) s = MINV;  // clip low
    return s[DW-1:0];
  endfunction

  function automatic logic [DW-1:0] ref_dac_code(input logic signed [DW-1:0] v);
    int c;
    c = MAXV - int'(v);  // zero maps to mid code
    return c[DW-1:0];
  endfunction

  // radio sample scaled down to the DAC width
  function automatic logic [DW-1:0] ref_rb_code(input logic signed [RB_W-1:0] r);
    int q;
    q = int'(r) >>> (RB_W - DW);
    return ref_dac_code(q[DW-1:0]);
  endfunction

  function automatic logic [31:0] region_addr(input int rgn, input logic [REGION_LSB-1:0] ofs);
    logic [31:0] a;
    a = '0;
    a[REGION_LSB +: 3]   = rgn[2:0];
    a[REGION_LSB-1:0]    = ofs;
    return a;
  endfunction

  // ------------------------------------------------------------
  // failure reporting and checks
  // ------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  // ------------------------------------------------------------
  // stimulus helpers, inputs change 1 ns after the edge
  // ------------------------------------------------------------
  task automatic drive_random();
    @(posedge adc_clk);
    #1;
    adc_dat_a = 16'($urandom);
    adc_dat_b = 16'($urandom);
    gen_a     = DW'($urandom);
    gen_b     = DW'($urandom);
    ctl_a     = DW'($urandom);
    ctl_b     = DW'($urandom);
    rb_a      = RB_W'($urandom);
    rb_b      = RB_W'($urandom);
    rb_led    = 8'($urandom);
  endtask

  task automatic drive_sums(input int ga, input int ca, input int gb, input int cb);
    @(posedge adc_clk);
    #1;
    gen_a = DW'(ga);
    ctl_a = DW'(ca);
    gen_b = DW'(gb);
    ctl_b = DW'(cb);
  endtask

  // overflow both ways plus a few in range
  task automatic drive_extremes();
    drive_sums(MAXV, MAXV, MINV, MINV);
    drive_sums(MAXV, 1, MINV, -1);
    drive_sums(MINV, -1, MAXV, 1);
    drive_sums(MAXV, MINV, MINV, MAXV);
    drive_sums(4096, 4096, -4096, -4097);
    drive_sums(0, 0, -1, 0);
  endtask

  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic write, output logic [31:0] rdata, output logic err);
    int waited;
    @(posedge adc_clk);
    #1;
    req.addr  = addr;
    req.wdata = wdata;
    req.wen   = write;
    req.ren   = ~write;
    @(posedge adc_clk);
    #1;
    req.wen = 1'b0;  // single cycle strobe
    req.ren = 1'b0;
    waited  = 0;
    while (!rsp.ack && waited < ACK_WAIT) begin
      @(posedge adc_clk);
      #1;
      waited++;
    end
    if (!rsp.ack) begin
      abort_run($sformatf("bus access to 0x%08h was never acknowledged", addr));
    end else begin
      rdata = rsp.rdata;
      err   = rsp.err;
    end
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_access(addr, data, 1'b1, rd, err);
    check_val("rsp_o.err", 32'(err), 32'(exp_err));
    check_val("rsp_o.rdata", rd, 32'h0);  // writes return zero
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp_data,
                          input logic exp_err);
    logic [31:0] rd;
    logic        err;
    bus_access(addr, 32'h0, 1'b0, rd, err);
    check_val("rsp_o.err", 32'(err), 32'(exp_err));
    check_val("rsp_o.rdata", rd, exp_data);
  endtask

  // ------------------------------------------------------------
  // reference model, advances on each rising edge
  // ------------------------------------------------------------
  always @(posedge adc_clk) begin
    if (reset_i) begin
      mdl_cfg    <= '0;
      adc_code_a <= '0;
      adc_code_b <= '0;
      exp_dac_a  <= DW'(MAXV);  // zero sample code
      exp_dac_b  <= DW'(MAXV);
    end else begin
      adc_code_a <= adc_dat_a[RAW_W-1 -: DW];
      adc_code_b <= adc_dat_b[RAW_W-1 -: DW];
      exp_dac_a  <= mdl_cfg.rb_active ? ref_rb_code(rb_a) : ref_dac_code(ref_sat_sum(gen_a, ctl_a));
      exp_dac_b  <= mdl_cfg.rb_active ? ref_rb_code(rb_b) : ref_dac_code(ref_sat_sum(gen_b, ctl_b));
      if (req.wen && req.addr[REGION_LSB +: 3] == 3'd0) begin
        case (req.addr[REGION_LSB-1:0])
          HK_LOOP_OFS: mdl_cfg.digital_loop <= req.wdata[0];
          HK_LED_OFS:  mdl_cfg.hk_led       <= req.wdata[7:0];
          HK_RB_OFS:   mdl_cfg.rb_active    <= req.wdata[0];
          default:     ;
        endcase
      end
    end
    pred_valid <= 1'b1;
  end

  // compare on the falling edge, everything settled
  always @(negedge adc_clk) begin
    if (u_rp_analog_top.u_bus_ctrl.u_assertions.fail_cnt != 0) begin
      abort_run("a bus protocol assertion failed");
    end
    if (pred_valid) begin
      if (mdl_cfg.digital_loop) begin
        exp_adc_a = ref_sat_sum(gen_a, ctl_a);  // same cycle as the inputs
        exp_adc_b = ref_sat_sum(gen_b, ctl_b);
      end else begin
        exp_adc_a = ref_adc_conv(adc_code_a);
        exp_adc_b = ref_adc_conv(adc_code_b);
      end
      exp_led = mdl_cfg.rb_active ? rb_led : mdl_cfg.hk_led;
      check_val("dac_a_o", 32'(dac_a), 32'(exp_dac_a));
      check_val("dac_b_o", 32'(dac_b), 32'(exp_dac_b));
      check_val("adc_a_o", 32'(adc_a), 32'(exp_adc_a));
      check_val("adc_b_o", 32'(adc_b), 32'(exp_adc_b));
      check_val("led_o", 32'(led), 32'(exp_led));
    end
  end

  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial begin
    adc_clk    = 1'b0;
    reset_i    = 1'b1;
    adc_dat_a  = '0;
    adc_dat_b  = '0;
    gen_a      = '0;
    gen_b      = '0;
    ctl_a      = '0;
    ctl_b      = '0;
    rb_a       = '0;
    rb_b       = '0;
    rb_led     = '0;
    req        = '0;
    req.ren    = 1'b1;  // read strobe inside reset, never acked
    pred_valid = 1'b0;
    cycle_cnt  = 0;
    void'($urandom(39));

    repeat (RESET_CYCLES-1) @(posedge adc_clk);
    #1;
    req.ren = 1'b0;  // strobe gone one edge before release
    @(posedge adc_clk);
    #1;
    reset_i = 1'b0;
    check_val("dac_a_o", 32'(dac_a), 32'h1FFF);
    check_val("dac_b_o", 32'(dac_b), 32'h1FFF);
    check_val("led_o", 32'(led), 32'h0);
    check_val("rsp_o.ack", 32'(rsp.ack), 32'h0);

    repeat (N_ADC) drive_random();  // loopback off
    repeat (N_DAC) drive_random();
    drive_extremes();

    // register map
    bus_read(region_addr(0, HK_ID_OFS), HK_ID_VALUE, 1'b0);
    bus_write(region_addr(0, HK_ID_OFS), 32'h0000_1234, 1'b0);  // dropped
    bus_read(region_addr(0, HK_ID_OFS), HK_ID_VALUE, 1'b0);
    bus_write(region_addr(0, HK_LED_OFS), 32'h0000_00A5, 1'b0);
    bus_read(region_addr(0, HK_LED_OFS), 32'h0000_00A5, 1'b0);
    bus_write(region_addr(0, HK_LOOP_OFS), 32'h1, 1'b0);
    bus_read(region_addr(0, HK_LOOP_OFS), 32'h1, 1'b0);
    bus_write(region_addr(0, HK_LOOP_OFS), 32'h0, 1'b0);
    bus_read(region_addr(0, HK_LOOP_OFS), 32'h0, 1'b0);
    bus_write(region_addr(0, HK_RB_OFS), 32'h1, 1'b0);
    bus_read(region_addr(0, HK_RB_OFS), 32'h1, 1'b0);
    bus_write(region_addr(0, HK_RB_OFS), 32'h0, 1'b0);
    bus_read(region_addr(0, HK_RB_OFS), 32'h0, 1'b0);
    bus_read(region_addr(0, 20'h0_0010), 32'h0, 1'b1);  // hole in region 0
    bus_write(region_addr(0, 20'h0_0014), 32'hFFFF_FFFF, 1'b1);
    for (int r = 1; r < N_REGIONS; r++) begin
      bus_read(region_addr(r, HK_ID_OFS), 32'h0, 1'b0);    // id lives in region 0 only
      bus_read(region_addr(r, 20'h0_0010), 32'h0, 1'b0);   // no hole error outside region 0
    end
    bus_write(region_addr(3, HK_LED_OFS), 32'h0000_00FF, 1'b0);

    // loopback
    bus_write(region_addr(0, HK_LOOP_OFS), 32'h1, 1'b0);
    repeat (N_LOOP) drive_random();
    drive_extremes();
    bus_write(region_addr(0, HK_LOOP_OFS), 32'h0, 1'b0);

    // radio override and led select
    bus_write(region_addr(0, HK_LED_OFS), 32'h0000_003C, 1'b0);
    bus_write(region_addr(0, HK_RB_OFS), 32'h1, 1'b0);
    repeat (N_RB) drive_random();
    bus_write(region_addr(0, HK_RB_OFS), 32'h0, 1'b0);
    check_val("led_o", 32'(led), 32'h3C);
    repeat (4) drive_random();

    if (u_rp_analog_top.u_bus_ctrl.u_assertions.fail_cnt != 0) begin
      abort_run("a bus protocol assertion failed");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: all.f
rtl/rp_pkg.sv
rtl/rp_bus_ctrl.sv
rtl/rp_adc_frontend.sv
rtl/rp_dac_backend.sv
rtl/rp_analog_top.sv
bench/rp_analog_assertions.sv
bench/tb_rp_analog.sv

// File: Makefile
# Verilator build and run of the analog front end testbench

VERILATOR ?= verilator
TOP       ?= tb_rp_analog
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
